// File: logic/eval_cfg.svh
// Evaluator configuration.
// Score widths, piece values and piece-square bonus weights.
`ifndef EVAL_CFG_SVH
`define EVAL_CFG_SVH

// signed width of a whole-board score.
`define EVAL_WIDTH 16

// signed width of one square's score.
`define SCORE_SQ_WIDTH 12

// material value of each piece kind.
`define VALUE_PAWN   100
`define VALUE_KNIGHT 320
`define VALUE_BISHOP 330
`define VALUE_ROOK   500
`define VALUE_QUEEN  900
`define VALUE_KING   0

// middlegame bonus per step of centralisation for knight and bishop.
`define PST_CENTER_MG 4

// middlegame bonus per rank of pawn advance.
`define PST_PAWN_MG 5

// endgame bonus per step of king centralisation.
`define PST_CENTER_EG 6

// endgame bonus per rank of pawn advance.
`define PST_PAWN_EG 10

`endif

// File: logic/eval_pkg.sv
// Evaluator types.
// Piece codes, the square word with its two decodings, the board and the result.
`default_nettype none

`include "eval_cfg.svh"

package eval_pkg;

   typedef enum logic [2:0] {
      kind_empty  = 3'd0,
      kind_pawn   = 3'd1,
      kind_knight = 3'd2,
      kind_bishop = 3'd3,
      kind_rook   = 3'd4,
      kind_queen  = 3'd5,
      kind_king   = 3'd6
   } piece_kind_t;

   // Field view of a square. White pieces are 1 to 6, black pieces 9 to 14.
   typedef struct packed {
      logic        black;
      piece_kind_t kind;
   } square_fields_t;

   typedef union packed {
      logic [3:0]     raw;     // used as the table index.
      square_fields_t field;   // used for colour and kind tests.
   } square_u;

   // 64 squares, index is rank * 8 + file.
   typedef square_u [63:0] board_t;

   typedef struct packed {
      logic signed [`SCORE_SQ_WIDTH-1:0] mg;
      logic signed [`SCORE_SQ_WIDTH-1:0] eg;
   } sq_score_t;

   typedef struct packed {
      logic                          insufficient;
      logic signed [`EVAL_WIDTH-1:0] mg;
      logic signed [`EVAL_WIDTH-1:0] eg;
   } eval_result_t;

endpackage

`default_nettype wire

// File: logic/piece_square_scorer.sv
// Per-square scorer of the evaluator.
// Looks up value plus piece-square bonus for every square and registers it at t1.
`default_nettype none

`include "eval_cfg.svh"

module piece_square_scorer
(
   input  wire logic                          clk,
   input  wire logic                          arst_n,
   input  wire logic                          board_valid,
   input  wire eval_pkg::board_t              board,
   output logic signed [`SCORE_SQ_WIDTH-1:0]  sq_mg [64],
   output logic signed [`SCORE_SQ_WIDTH-1:0]  sq_eg [64],
   output logic                               sq_valid
);

   import eval_pkg::*;

   logic signed [`SCORE_SQ_WIDTH-1:0] value_tbl [16];
   logic signed [`SCORE_SQ_WIDTH-1:0] pst_mg [16][64];
   logic signed [`SCORE_SQ_WIDTH-1:0] pst_eg [16][64];
   sq_score_t                         score_q [64];

   // Distance in steps from the board edge, 0 in a corner and 6 in the centre.
   function automatic int centre_steps(input int sq_idx);
      int file;
      int rank;
      file = sq_idx % 8;
      rank = sq_idx / 8;
      return ((file < 7 - file) ? file : 7 - file) + ((rank < 7 - rank) ? rank : 7 - rank);
   endfunction

   function automatic logic signed [`SCORE_SQ_WIDTH-1:0] piece_value(input int code);
      square_u s;
      int      v;
      s.raw = code[3:0];
      case (s.field.kind)
         kind_pawn:   v = `VALUE_PAWN;
         kind_knight: v = `VALUE_KNIGHT;
         kind_bishop: v = `VALUE_BISHOP;
         kind_rook:   v = `VALUE_ROOK;
         kind_queen:  v = `VALUE_QUEEN;
         kind_king:   v = `VALUE_KING;
         default:     v = 0;
      endcase
      if (s.field.black)
         v = -v;
      return v[`SCORE_SQ_WIDTH-1:0];
   endfunction

   function automatic logic signed [`SCORE_SQ_WIDTH-1:0] pst_bonus(input int   code,
                                                                    input int   sq_idx,
                                                                    input logic endgame);
      square_u s;
      int      advance;
      int      b;
      s.raw   = code[3:0];
      advance = s.field.black ? 7 - sq_idx / 8 : sq_idx / 8;   // ranks gained from home side.
      b       = 0;
      if (s.field.kind == kind_pawn)
         b = advance * (endgame ? `PST_PAWN_EG : `PST_PAWN_MG);
      else if (!endgame && (s.field.kind == kind_knight || s.field.kind == kind_bishop))
         b = centre_steps(sq_idx) * `PST_CENTER_MG;
      else if (endgame && s.field.kind == kind_king)
         b = centre_steps(sq_idx) * `PST_CENTER_EG;
      if (s.field.black)
         b = -b;
      return b[`SCORE_SQ_WIDTH-1:0];
   endfunction

   for (genvar code = 0; code < 16; code++)
   begin : g_code
      assign value_tbl[code] = piece_value(code);
      for (genvar sq = 0; sq < 64; sq++)
      begin : g_sq
         assign pst_mg[code][sq] = pst_bonus(code, sq, 1'b0);
         assign pst_eg[code][sq] = pst_bonus(code, sq, 1'b1);
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         sq_valid <= 1'b0;
      else
         sq_valid <= board_valid;
   end

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < 64; i++)
      begin
         score_q[i].mg <= value_tbl[board[i].raw] + pst_mg[board[i].raw][i];
         score_q[i].eg <= value_tbl[board[i].raw] + pst_eg[board[i].raw][i];
      end
   end

   for (genvar i = 0; i < 64; i++)
   begin : g_out
      assign sq_mg[i] = score_q[i].mg;
      assign sq_eg[i] = score_q[i].eg;
   end

endmodule

`default_nettype wire

// File: logic/score_reduction_tree.sv
// Score adder tree of the evaluator.
// Sums the 64 square scores over t2 to t6 and carries the valid bit along.
`default_nettype none

`include "eval_cfg.svh"

module score_reduction_tree
(
   input  wire logic                              clk,
   input  wire logic                              arst_n,
   input  wire logic signed [`SCORE_SQ_WIDTH-1:0] sq_mg [64],
   input  wire logic signed [`SCORE_SQ_WIDTH-1:0] sq_eg [64],
   input  wire logic                              sq_valid,
   output logic signed [`EVAL_WIDTH-1:0]          sum_mg,
   output logic signed [`EVAL_WIDTH-1:0]          sum_eg,
   output logic                                   sum_valid
);

   // group g holds squares 4g to 4g+3, half a rank.
   logic signed [`EVAL_WIDTH-1:0] grp_mg_t2 [16];
   logic signed [`EVAL_WIDTH-1:0] grp_eg_t2 [16];
   logic signed [`EVAL_WIDTH-1:0] grp_mg_t3 [16];
   logic signed [`EVAL_WIDTH-1:0] grp_eg_t3 [16];
   // pair p holds ranks 2p and 2p+1.
   logic signed [`EVAL_WIDTH-1:0] pair_mg_t4 [4];
   logic signed [`EVAL_WIDTH-1:0] pair_eg_t4 [4];
   logic signed [`EVAL_WIDTH-1:0] pair_mg_t5 [4];
   logic signed [`EVAL_WIDTH-1:0] pair_eg_t5 [4];
   logic [3:0]                    valid_sr;   // valid of stages t2 to t5.

   function automatic logic signed [`EVAL_WIDTH-1:0] add4(input logic signed [`EVAL_WIDTH-1:0] a,
                                                          input logic signed [`EVAL_WIDTH-1:0] b,
                                                          input logic signed [`EVAL_WIDTH-1:0] c,
                                                          input logic signed [`EVAL_WIDTH-1:0] d);
      return a + b + c + d;
   endfunction

   always_ff @(posedge clk)
   begin
      for (int g = 0; g < 16; g++)
      begin
         grp_mg_t2[g] <= add4(sq_mg[4*g], sq_mg[4*g+1], sq_mg[4*g+2], sq_mg[4*g+3]);
         grp_eg_t2[g] <= add4(sq_eg[4*g], sq_eg[4*g+1], sq_eg[4*g+2], sq_eg[4*g+3]);
      end

      grp_mg_t3 <= grp_mg_t2;   // balances the stage depth.
      grp_eg_t3 <= grp_eg_t2;

      for (int p = 0; p < 4; p++)
      begin
         pair_mg_t4[p] <= add4(grp_mg_t3[4*p], grp_mg_t3[4*p+1],
                               grp_mg_t3[4*p+2], grp_mg_t3[4*p+3]);
         pair_eg_t4[p] <= add4(grp_eg_t3[4*p], grp_eg_t3[4*p+1],
                               grp_eg_t3[4*p+2], grp_eg_t3[4*p+3]);
      end

      pair_mg_t5 <= pair_mg_t4;
      pair_eg_t5 <= pair_eg_t4;

      sum_mg <= add4(pair_mg_t5[0], pair_mg_t5[1], pair_mg_t5[2], pair_mg_t5[3]);
      sum_eg <= add4(pair_eg_t5[0], pair_eg_t5[1], pair_eg_t5[2], pair_eg_t5[3]);
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         valid_sr  <= '0;
         sum_valid <= 1'b0;
      end
      else
      begin
         valid_sr  <= {valid_sr[2:0], sq_valid};
         sum_valid <= valid_sr[3];
      end
   end

endmodule

`default_nettype wire

// File: logic/material_census.sv
// Material census of the evaluator.
// Weighs non-king material of both sides and flags insufficient material at t7.
`default_nettype none

module material_census
(
   input  wire logic             clk,
   input  wire logic             arst_n,
   input  wire eval_pkg::board_t board,
   output logic                  insufficient
);

   import eval_pkg::*;

   logic [1:0] white_w_t1 [64];
   logic [1:0] black_w_t1 [64];
   logic [4:0] white_rank_t2 [8];
   logic [4:0] black_rank_t2 [8];
   logic [7:0] white_total_t3;
   logic [7:0] black_total_t3;
   logic       flag_t4;
   logic       flag_t5;
   logic       flag_t6;

   // a weight of 3 alone is always enough material to mate.
   function automatic logic [1:0] weight(input square_u sq);
      case (sq.field.kind)
         kind_pawn, kind_rook, kind_queen: return 2'd3;
         kind_knight, kind_bishop:         return 2'd1;
         default:                          return 2'd0;
      endcase
   endfunction

   function automatic logic [4:0] rank_sum(input logic [1:0] w [64], input int rank);
      logic [4:0] acc;
      acc = '0;
      for (int f = 0; f < 8; f++)
         acc = acc + w[rank*8+f];
      return acc;
   endfunction

   function automatic logic [7:0] board_sum(input logic [4:0] r [8]);
      logic [7:0] acc;
      acc = '0;
      for (int i = 0; i < 8; i++)
         acc = acc + r[i];
      return acc;
   endfunction

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < 64; i++)
      begin
         white_w_t1[i] <= board[i].field.black ? 2'd0 : weight(board[i]);
         black_w_t1[i] <= board[i].field.black ? weight(board[i]) : 2'd0;
      end
      for (int r = 0; r < 8; r++)
      begin
         white_rank_t2[r] <= rank_sum(white_w_t1, r);
         black_rank_t2[r] <= rank_sum(black_w_t1, r);
      end
      white_total_t3 <= board_sum(white_rank_t2);
      black_total_t3 <= board_sum(black_rank_t2);
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         flag_t4      <= 1'b0;
         flag_t5      <= 1'b0;
         flag_t6      <= 1'b0;
         insufficient <= 1'b0;
      end
      else
      begin
         flag_t4      <= (white_total_t3 == 8'd0 && black_total_t3 <= 8'd1) ||
                         (white_total_t3 <= 8'd1 && black_total_t3 == 8'd0);
         flag_t5      <= flag_t4;
         flag_t6      <= flag_t5;
         insufficient <= flag_t6;   // lines up with the scores at t7.
      end
   end

endmodule

`default_nettype wire

// File: logic/score_jitter.sv
// Random score offset of the evaluator.
// Adds a masked signed random offset to both sums and registers the t7 result.
`default_nettype none

`include "eval_cfg.svh"

module score_jitter
(
   input  wire logic                          clk,
   input  wire logic                          arst_n,
   input  wire logic [`EVAL_WIDTH-1:0]        random_number,
   input  wire logic [`EVAL_WIDTH-1:0]        random_score_mask,
   input  wire logic signed [`EVAL_WIDTH-1:0] sum_mg,
   input  wire logic signed [`EVAL_WIDTH-1:0] sum_eg,
   input  wire logic                          sum_valid,
   output logic signed [`EVAL_WIDTH-1:0]      eval_mg,
   output logic signed [`EVAL_WIDTH-1:0]      eval_eg,
   output logic                               eval_valid
);

   logic [`EVAL_WIDTH-1:0]        magnitude;
   logic signed [`EVAL_WIDTH-1:0] offset_q;

   // top bit of the magnitude is always clear, so it never reads as negative.
   assign magnitude = {1'b0, random_number[`EVAL_WIDTH-2:0]} & random_score_mask;

   always_ff @(posedge clk)
   begin
      if (random_number[`EVAL_WIDTH-1])
         offset_q <= $signed(magnitude);
      else
         offset_q <= -$signed(magnitude);
      eval_mg <= sum_mg + offset_q;
      eval_eg <= sum_eg + offset_q;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         eval_valid <= 1'b0;
      else
         eval_valid <= sum_valid;
   end

endmodule

`default_nettype wire

// File: logic/evaluate_general.sv
// Static board evaluator, top level.
// Seven-cycle pipeline from a board to middlegame, endgame and material results.
`default_nettype none

`include "eval_cfg.svh"

module evaluate_general
(
   input  wire logic                   clk,
   input  wire logic                   arst_n,
   input  wire logic                   board_valid,
   input  wire eval_pkg::board_t       board,
   input  wire logic [`EVAL_WIDTH-1:0] random_number,
   input  wire logic [`EVAL_WIDTH-1:0] random_score_mask,
   output logic                        eval_valid,
   output eval_pkg::eval_result_t      eval
);

   logic signed [`SCORE_SQ_WIDTH-1:0] sq_mg [64];
   logic signed [`SCORE_SQ_WIDTH-1:0] sq_eg [64];
   logic                              sq_valid;
   logic signed [`EVAL_WIDTH-1:0]     sum_mg;
   logic signed [`EVAL_WIDTH-1:0]     sum_eg;
   logic                              sum_valid;
   logic signed [`EVAL_WIDTH-1:0]     eval_mg;
   logic signed [`EVAL_WIDTH-1:0]     eval_eg;
   logic                              insufficient;

   piece_square_scorer u_scorer (
      .clk         (clk),
      .arst_n      (arst_n),
      .board_valid (board_valid),
      .board       (board),
      .sq_mg       (sq_mg),
      .sq_eg       (sq_eg),
      .sq_valid    (sq_valid)
   );

   score_reduction_tree u_tree (
      .clk       (clk),
      .arst_n    (arst_n),
      .sq_mg     (sq_mg),
      .sq_eg     (sq_eg),
      .sq_valid  (sq_valid),
      .sum_mg    (sum_mg),
      .sum_eg    (sum_eg),
      .sum_valid (sum_valid)
   );

   material_census u_census (
      .clk          (clk),
      .arst_n       (arst_n),
      .board        (board),
      .insufficient (insufficient)
   );

   score_jitter u_jitter (
      .clk               (clk),
      .arst_n            (arst_n),
      .random_number     (random_number),
      .random_score_mask (random_score_mask),
      .sum_mg            (sum_mg),
      .sum_eg            (sum_eg),
      .sum_valid         (sum_valid),
      .eval_mg           (eval_mg),
      .eval_eg           (eval_eg),
      .eval_valid        (eval_valid)
   );

   assign eval = '{insufficient: insufficient, mg: eval_mg, eg: eval_eg};

endmodule

`default_nettype wire

// File: bench/eval_model.svh
// Reference model of the board evaluator.
// Rebuilds the piece-square rule, the material census and the random offset.
`ifndef EVAL_MODEL_SVH
`define EVAL_MODEL_SVH

`include "eval_cfg.svh"

// steps from the nearest edges, 0 in a corner and 6 in the centre.
function automatic int edge_distance(input int sq);
   int file;
   int rank;
   int df;
   int dr;
   file = sq % 8;
   rank = sq / 8;
   df   = (file < 7 - file) ? file : 7 - file;
   dr   = (rank < 7 - rank) ? rank : 7 - rank;
   return df + dr;
endfunction

function automatic int kind_value(input int kind);
   case (kind)
      1:       return `VALUE_PAWN;
      2:       return `VALUE_KNIGHT;
      3:       return `VALUE_BISHOP;
      4:       return `VALUE_ROOK;
      5:       return `VALUE_QUEEN;
      6:       return `VALUE_KING;
      default: return 0;
   endcase
endfunction

function automatic int square_score(input logic [3:0] code, input int sq, input bit endgame);
   int kind;
   int advance;
   int bonus;
   int score;
   kind    = int'(code[2:0]);
   advance = code[3] ? 7 - sq / 8 : sq / 8;   // black pawns advance towards rank 0.
   bonus   = 0;
   if (kind == 1)
      bonus = advance * (endgame ? `PST_PAWN_EG : `PST_PAWN_MG);
   else if (!endgame && (kind == 2 || kind == 3))
      bonus = edge_distance(sq) * `PST_CENTER_MG;
   else if (endgame && kind == 6)
      bonus = edge_distance(sq) * `PST_CENTER_EG;
   score = (kind == 0 || kind == 7) ? 0 : kind_value(kind) + bonus;
   return code[3] ? -score : score;
endfunction

function automatic int board_score(input board_t b, input bit endgame);
   int sum;
   sum = 0;
   for (int i = 0; i < 64; i++)
      sum += square_score(b[i].raw, i, endgame);
   return sum;
endfunction

// pawns, rooks and queens count 3, minor pieces 1.
function automatic int side_material(input board_t b, input bit black);
   int sum;
   int kind;
   sum = 0;
   for (int i = 0; i < 64; i++)
   begin
      kind = int'(b[i].raw[2:0]);
      if (b[i].raw[3] == black)
      begin
         if (kind == 1 || kind == 4 || kind == 5)
            sum += 3;
         else if (kind == 2 || kind == 3)
            sum += 1;
      end
   end
   return sum;
endfunction

function automatic bit insufficient_material(input board_t b);
   int w;
   int k;
   w = side_material(b, 1'b0);
   k = side_material(b, 1'b1);
   return (w == 0 && k <= 1) || (w <= 1 && k == 0);
endfunction

function automatic int jitter_offset(input logic [`EVAL_WIDTH-1:0] rnd,
                                     input logic [`EVAL_WIDTH-1:0] mask);
   int mag;
   mag = int'(rnd[`EVAL_WIDTH-2:0] & mask[`EVAL_WIDTH-2:0]);
   return rnd[`EVAL_WIDTH-1] ? mag : -mag;
endfunction

// scores before the offset, wrapped to the result width.
function automatic eval_result_t expected_result(input board_t b);
   eval_result_t r;
   int           mg;
   int           eg;
   mg             = board_score(b, 1'b0);
   eg             = board_score(b, 1'b1);
   r.insufficient = insufficient_material(b);
   r.mg           = mg[`EVAL_WIDTH-1:0];
   r.eg           = eg[`EVAL_WIDTH-1:0];
   return r;
endfunction

`endif

// File: bench/evaluate_general_tb.sv
// Testbench for the board evaluator.
// Random boards checked against a reference model for timing, scores, offset and material.
`default_nettype none

`include "eval_cfg.svh"

module evaluate_general_tb;

   import eval_pkg::*;

   `include "eval_model.svh"

   localparam int GAP_BOARDS      = 200;
   localparam int B2B_BOARDS      = 100;
   localparam int MIRROR_PAIRS    = 40;
   localparam int OFFSET_BOARDS   = 200;
   localparam int MATERIAL_BOARDS = 150;
   localparam int TAIL_CYCLES     = 12;
   localparam int NUM_BOARDS      = GAP_BOARDS + B2B_BOARDS + 2 * MIRROR_PAIRS +
                                    OFFSET_BOARDS + MATERIAL_BOARDS;
   localparam int WATCHDOG_TIME   = NUM_BOARDS * 4 + 200;
   localparam int HIST_DEPTH      = NUM_BOARDS + 64;
   localparam int LATENCY         = 7;   // a board driven after edge n shows at edge n+7.
   localparam int OFFSET_LAG      = 5;   // offset inputs are sampled at edge n+6.

   localparam int PH_GAPS     = 0;
   localparam int PH_B2B      = 1;
   localparam int PH_MIRROR   = 2;
   localparam int PH_OFFSET   = 3;
   localparam int PH_MATERIAL = 4;

   logic                   clk;
   logic                   arst_n;
   logic                   board_valid;
   board_t                 board;
   logic [`EVAL_WIDTH-1:0] random_number;
   logic [`EVAL_WIDTH-1:0] random_score_mask;
   logic                   eval_valid;
   eval_result_t           eval;

   int                     edge_cnt = 0;
   bit                     valid_hist [HIST_DEPTH];
   logic [`EVAL_WIDTH-1:0] rnd_hist [HIST_DEPTH];
   logic [`EVAL_WIDTH-1:0] mask_hist [HIST_DEPTH];
   eval_result_t           exp_q [$];
   int                     cycle_q [$];
   int                     phase_q [$];

   evaluate_general dut (
      .clk               (clk),
      .arst_n            (arst_n),
      .board_valid       (board_valid),
      .board             (board),
      .random_number     (random_number),
      .random_score_mask (random_score_mask),
      .eval_valid        (eval_valid),
      .eval              (eval)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk)
      edge_cnt <= edge_cnt + 1;

   function automatic string phase_name(input int phase);
      case (phase)
         PH_GAPS:   return "reset_and_gaps";
         PH_B2B:    return "back_to_back";
         PH_MIRROR: return "mirror";
         PH_OFFSET: return "offset";
         default:   return "material";
      endcase
   endfunction

   function automatic logic [`EVAL_WIDTH-1:0] rand_word();
      int r;
      r = $urandom;
      return r[`EVAL_WIDTH-1:0];
   endfunction

   function automatic board_t random_board();
      board_t b;
      int     k;
      for (int i = 0; i < 64; i++)
      begin
         k = $urandom_range(6, 1);
         if ($urandom_range(1, 0) == 0)
            b[i].raw = 4'd0;
         else
            b[i].raw = {$urandom_range(1, 0) == 1, k[2:0]};
      end
      return b;
   endfunction

   function automatic board_t place_piece(input board_t b, input logic [3:0] code);
      int sq;
      sq = $urandom_range(63, 0);
      while (b[sq].raw != 4'd0)
         sq = $urandom_range(63, 0);
      b[sq].raw = code;
      return b;
   endfunction

   function automatic logic [3:0] minor_code(input bit black);
      return {black, ($urandom_range(1, 0) == 0) ? kind_knight : kind_bishop};
   endfunction

   function automatic logic [3:0] heavy_code(input bit black);
      piece_kind_t k;
      case ($urandom_range(2, 0))
         0:       k = kind_pawn;
         1:       k = kind_rook;
         default: k = kind_queen;
      endcase
      return {black, k};
   endfunction

   // both kings, plus nothing, a minor, a heavy piece, two minors, or one minor each.
   function automatic board_t sparse_board(input int mode);
      board_t b;
      bit     side;
      b    = '0;
      side = $urandom_range(1, 0);
      b    = place_piece(b, {1'b0, kind_king});
      b    = place_piece(b, {1'b1, kind_king});
      case (mode)
         1: b = place_piece(b, minor_code(side));
         2: b = place_piece(b, heavy_code(side));
         3:
         begin
            b = place_piece(b, minor_code(side));
            b = place_piece(b, minor_code(side));
         end
         4:
         begin
            b = place_piece(b, minor_code(1'b0));
            b = place_piece(b, minor_code(1'b1));
         end
         default: ;
      endcase
      return b;
   endfunction

   // flips the ranks and swaps the colours.
   function automatic board_t mirror_board(input board_t b);
      board_t m;
      for (int r = 0; r < 8; r++)
         for (int f = 0; f < 8; f++)
            m[(7 - r) * 8 + f].raw = (b[r * 8 + f].raw[2:0] == 3'd0) ? 4'd0 :
                                     b[r * 8 + f].raw ^ 4'b1000;
      return m;
   endfunction

   task automatic check_valid(input string test, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("[FAIL] %s: expected eval_valid=%b, actual eval_valid=%b", test, exp, act);
         $display("** FAIL **");
         $fatal(1, "eval_valid mismatch");
      end
   endtask

   task automatic check_result(input string test, input eval_result_t exp,
                               input eval_result_t act);
      if (act !== exp)
      begin
         $display("[FAIL] %s: expected mg=%0d eg=%0d insufficient=%b, actual mg=%0d eg=%0d %s%b",
                  test, exp.mg, exp.eg, exp.insufficient, act.mg, act.eg,
                  "insufficient=", act.insufficient);
         $display("** FAIL **");
         $fatal(1, "eval result mismatch");
      end
   endtask

   task automatic drive_board(input bit valid, input board_t brd,
                              input logic [`EVAL_WIDTH-1:0] mask, input int phase);
      int                     idx;
      logic [`EVAL_WIDTH-1:0] rnd;
      @(posedge clk);
      #1;
      idx               = edge_cnt;
      rnd               = rand_word();
      board_valid       = valid;
      board             = brd;
      random_number     = rnd;
      random_score_mask = mask;
      valid_hist[idx]   = valid;
      rnd_hist[idx]     = rnd;
      mask_hist[idx]    = mask;
      if (valid)
      begin
         exp_q.push_back(expected_result(brd));
         cycle_q.push_back(idx);
         phase_q.push_back(phase);
      end
   endtask

   always @(negedge clk)
   begin : output_check
      logic         exp_valid;
      eval_result_t exp;
      int           cyc;
      int           phase;
      int           mg;
      int           eg;
      int           off;
      exp_valid = (edge_cnt >= LATENCY) ? valid_hist[edge_cnt - LATENCY] : 1'b0;
      check_valid("valid_timing", exp_valid, eval_valid);
      if (eval_valid === 1'b1)
      begin
         exp    = exp_q.pop_front();
         cyc    = cycle_q.pop_front();
         phase  = phase_q.pop_front();
         off    = jitter_offset(rnd_hist[cyc + OFFSET_LAG], mask_hist[cyc + OFFSET_LAG]);
         mg     = exp.mg + off;
         eg     = exp.eg + off;
         exp.mg = mg[`EVAL_WIDTH-1:0];
         exp.eg = eg[`EVAL_WIDTH-1:0];
         check_result(phase_name(phase), exp, eval);
      end
   end

   initial
   begin : watchdog
      #(WATCHDOG_TIME);
      $display("the run did not finish before the watchdog limit");
      $display("** FAIL **");
      $fatal(1, "watchdog timeout");
   end

   initial
   begin : stimulus
      board_t                 b;
      logic [`EVAL_WIDTH-1:0] m;
      void'($urandom(98));
      arst_n            = 1'b0;
      board_valid       = 1'b0;
      board             = '0;
      random_number     = '0;
      random_score_mask = '0;
      repeat (4) @(posedge clk);
      #1;
      arst_n = 1'b1;

      for (int i = 0; i < GAP_BOARDS; i++)
      begin
         b = ($urandom_range(7, 0) == 0) ? sparse_board($urandom_range(4, 0)) : random_board();
         drive_board($urandom_range(99, 0) < 70, b, rand_word(), PH_GAPS);
      end

      for (int i = 0; i < B2B_BOARDS; i++)
         drive_board(1'b1, random_board(), '0, PH_B2B);

      for (int i = 0; i < MIRROR_PAIRS; i++)
      begin
         b = random_board();
         drive_board(1'b1, b, '0, PH_MIRROR);
         drive_board(1'b1, mirror_board(b), '0, PH_MIRROR);
      end

      for (int i = 0; i < OFFSET_BOARDS; i++)
      begin
         case ($urandom_range(3, 0))
            0:       m = '1;
            1:       m = 16'h00ff;
            2:       m = 16'h7fff;
            default: m = rand_word();
         endcase
         drive_board($urandom_range(99, 0) < 70, random_board(), m, PH_OFFSET);
      end

      for (int i = 0; i < MATERIAL_BOARDS; i++)
         drive_board(1'b1, sparse_board(i % 5), rand_word(), PH_MATERIAL);

      for (int i = 0; i < TAIL_CYCLES; i++)
         drive_board(1'b0, random_board(), rand_word(), PH_GAPS);

      @(negedge clk);
      #1;
      if (exp_q.size() == 0)
      begin
         $display("** PASS **");
         $finish;
      end
      else
      begin
         $display("%0d board results never appeared on the output", exp_q.size());
         $display("** FAIL **");
         $fatal(1, "missing results");
      end
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
+incdir+bench
logic/eval_pkg.sv
logic/piece_square_scorer.sv
logic/score_reduction_tree.sv
logic/material_census.sv
logic/score_jitter.sv
logic/evaluate_general.sv
bench/evaluate_general_tb.sv
